// ==== logic/bpu_pkg.sv ====
/* branch predictor shared definitions
   branch kinds, counter type, table hashing and counter update */
package bpu_pkg;

    typedef enum logic [1:0] {
        BR_NORMAL = 2'd0, // conditional
        BR_JUMP   = 2'd1, // plain unconditional
        BR_CALL   = 2'd2, // pushes the return address
        BR_RET    = 2'd3  // target comes from the stack
    } br_type_e;

    typedef logic [1:0] scnt_t; // msb set predicts taken

    // fold pc[3+] onto pc[9+], keep idx_w bits
    function automatic logic [31:0] btb_index(input logic [31:0] pc, input int unsigned idx_w);
        logic [31:0] keep;
        keep = (32'd1 << idx_w) - 32'd1;
        return ((pc >> 3) ^ (pc >> 9)) & keep;
    endfunction

    // tag bits start at pc[12]
    function automatic logic [31:0] btb_tag(input logic [31:0] pc, input int unsigned tag_w);
        logic [31:0] keep;
        keep = (32'd1 << tag_w) - 32'd1;
        return (pc >> 12) & keep;
    endfunction

    // saturating step toward 3 on taken, toward 0 otherwise
    function automatic scnt_t next_scnt(input scnt_t cnt, input logic taken);
        scnt_t nxt;
        nxt = cnt;
        if (taken && cnt != 2'd3) begin
            nxt = cnt + 2'd1;
        end else if (!taken && cnt != 2'd0) begin
            nxt = cnt - 2'd1;
        end
        return nxt;
    endfunction

endpackage

// ==== logic/bpu_pc_gen.sv ====
/* fetch pc register and next-pc selection
   picks the redirect target per slot and builds the two-slot mask */
`timescale 1ns/1ps

module bpu_pc_gen #(
    parameter logic [31:0] INIT_PC = 32'h1c00_0000
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush_i,
    input  logic [31:0]             redirect_pc_i,
    input  logic                    fetch_ready_i,
    input  logic [1:0]              slot_taken_i,
    input  bpu_pkg::br_type_e [1:0] slot_type_i,
    input  logic [1:0][31:0]        slot_target_i,
    input  logic [31:0]             ras_top_i,
    output logic [31:0]             fetch_pc_o,
    output logic [1:0][31:0]        target_o,
    output logic [1:0]              mask_o,
    output logic [31:0]             next_pc_o
);
    import bpu_pkg::*;

    logic [31:0] pc_q;    // current fetch pair
    logic [31:0] pc_seq;  // fall-through, next aligned pair
    logic        take0;   // slot 0 is live and redirects

    assign pc_seq = {pc_q[31:3] + 29'd1, 3'b000};
    assign take0  = slot_taken_i[0] & ~pc_q[2]; // slot 0 dead on odd entry

    // pc register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= INIT_PC;
        end else if (flush_i) begin // redirect wins over ready
            pc_q <= redirect_pc_i;
        end else if (fetch_ready_i) begin
            pc_q <= next_pc_o;
        end // else hold under back-pressure
    end

    // returns read the stack top, the rest use the btb target
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (slot_type_i[i] == BR_RET) begin
                target_o[i] = ras_top_i;
            end else begin
                target_o[i] = slot_target_i[i];
            end
        end
    end

    // oldest taken slot decides
    always_comb begin
        next_pc_o = pc_seq;
        if (take0) begin
            next_pc_o = target_o[0];
        end else if (slot_taken_i[1]) begin
            next_pc_o = target_o[1];
        end
    end

    assign mask_o[0]  = ~pc_q[2]; // entering at slot 1 skips slot 0
    assign mask_o[1]  = ~take0;   // squashed behind a taken slot 0
    assign fetch_pc_o = pc_q;

endmodule

// ==== logic/bpu_btb.sv ====
/* two-bank tagged branch target buffer
   bank per slot, read at the fetch pc, written by execute corrections */
`timescale 1ns/1ps

module bpu_btb #(
    parameter int BTB_IDX_W = 9,
    parameter int TAG_W     = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             fetch_pc_i,
    input  logic                    corr_update_i,
    input  logic [31:0]             corr_pc_i,
    input  logic [31:0]             corr_target_i,
    input  bpu_pkg::br_type_e       corr_br_type_i,
    input  logic                    corr_is_branch_i,
    input  logic                    corr_type_miss_i,
    input  logic                    corr_target_miss_i,
    output logic [1:0]              slot_hit_o,
    output bpu_pkg::br_type_e [1:0] slot_type_o,
    output logic [1:0][31:0]        slot_target_o,
    output logic [1:0]              tag_match_o
);
    import bpu_pkg::*;

    localparam int DEPTH = 1 << BTB_IDX_W;

    logic [1:0][DEPTH-1:0]             valid_q;  // entry written since reset
    logic [1:0][DEPTH-1:0][TAG_W-1:0]  tag_q;
    logic [1:0][DEPTH-1:0][1:0]        type_q;   // br_type_e encoding
    logic [1:0][DEPTH-1:0][31:0]       target_q;
    logic [1:0][DEPTH-1:0]             br_q;     // entry holds a branch

    logic [31:0]          rd_idx_full;
    logic [31:0]          wr_idx_full;
    logic [31:0]          rd_tag_full;
    logic [31:0]          wr_tag_full;
    logic [BTB_IDX_W-1:0] rd_idx;
    logic [BTB_IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0]     rd_tag;
    logic [TAG_W-1:0]     wr_tag;
    logic                 wr_en;
    logic                 wr_bank;

    assign rd_idx_full = btb_index(fetch_pc_i, BTB_IDX_W);
    assign wr_idx_full = btb_index(corr_pc_i, BTB_IDX_W);
    assign rd_tag_full = btb_tag(fetch_pc_i, TAG_W);
    assign wr_tag_full = btb_tag(corr_pc_i, TAG_W);
    assign rd_idx      = rd_idx_full[BTB_IDX_W-1:0];
    assign wr_idx      = wr_idx_full[BTB_IDX_W-1:0];
    assign rd_tag      = rd_tag_full[TAG_W-1:0];
    assign wr_tag      = wr_tag_full[TAG_W-1:0];
    assign wr_en       = corr_update_i & (corr_type_miss_i | corr_target_miss_i);
    assign wr_bank     = corr_pc_i[2]; // slot picks the bank

    // both banks share one index
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            tag_match_o[i]   = valid_q[i][rd_idx] & (tag_q[i][rd_idx] == rd_tag);
            slot_hit_o[i]    = tag_match_o[i] & br_q[i][rd_idx];
            slot_type_o[i]   = br_type_e'(type_q[i][rd_idx]);
            slot_target_o[i] = target_q[i][rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q  <= '0;
            tag_q    <= '0;
            type_q   <= '0;
            target_q <= '0;
            br_q     <= '0;
        end else if (wr_en) begin // only mispredicted records allocate
            valid_q[wr_bank][wr_idx]  <= 1'b1;
            tag_q[wr_bank][wr_idx]    <= wr_tag;
            type_q[wr_bank][wr_idx]   <= corr_br_type_i;
            target_q[wr_bank][wr_idx] <= corr_target_i;
            br_q[wr_bank][wr_idx]     <= corr_is_branch_i;
        end
    end

endmodule

// ==== logic/bpu_dir_pred.sv ====
/* direction predictor, local history per bank plus 2-bit counters
   counter index is {history, pc[3+]}, one shared counter table */
`timescale 1ns/1ps

module bpu_dir_pred #(
    parameter int BTB_IDX_W = 9,
    parameter int HIST_W    = 5,
    parameter int PHT_PC_W  = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             fetch_pc_i,
    input  logic [1:0]              slot_hit_i,
    input  bpu_pkg::br_type_e [1:0] slot_type_i,
    input  logic                    corr_update_i,
    input  logic [31:0]             corr_pc_i,
    input  logic                    corr_taken_i,
    input  logic                    corr_type_miss_i,
    input  logic [HIST_W-1:0]       corr_history_i,
    input  bpu_pkg::scnt_t          corr_scnt_i,
    output logic [1:0]              slot_taken_o,
    output logic [1:0][HIST_W-1:0]  slot_history_o,
    output bpu_pkg::scnt_t [1:0]    slot_scnt_o
);
    import bpu_pkg::*;

    localparam int BHT_DEPTH = 1 << BTB_IDX_W;
    localparam int PHT_W     = HIST_W + PHT_PC_W;
    localparam int PHT_DEPTH = 1 << PHT_W;

    logic [1:0][BHT_DEPTH-1:0][HIST_W-1:0] bht_q; // history, banked like the btb
    scnt_t [PHT_DEPTH-1:0]                 pht_q; // counters

    logic [31:0]           rd_idx_full;
    logic [31:0]           wr_idx_full;
    logic [BTB_IDX_W-1:0]  rd_idx;
    logic [BTB_IDX_W-1:0]  wr_idx;
    logic [PHT_PC_W-1:0]   rd_pc_bits;
    logic [1:0][PHT_W-1:0] pht_rd_idx;
    logic [PHT_W-1:0]      pht_wr_idx;
    logic [HIST_W-1:0]     hist_new;

    assign rd_idx_full = btb_index(fetch_pc_i, BTB_IDX_W);
    assign wr_idx_full = btb_index(corr_pc_i, BTB_IDX_W);
    assign rd_idx      = rd_idx_full[BTB_IDX_W-1:0];
    assign wr_idx      = wr_idx_full[BTB_IDX_W-1:0];
    assign rd_pc_bits  = fetch_pc_i[PHT_PC_W+2:3]; // same for both slots
    assign pht_wr_idx  = {corr_history_i, corr_pc_i[PHT_PC_W+2:3]}; // history seen at predict

    // lookup chain, history then counter
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            slot_history_o[i] = bht_q[i][rd_idx];
            pht_rd_idx[i]     = {slot_history_o[i], rd_pc_bits};
            slot_scnt_o[i]    = pht_q[pht_rd_idx[i]];
            // unconditional kinds always redirect on a hit
            slot_taken_o[i]   = slot_hit_i[i] &
                                ((slot_type_i[i] != BR_NORMAL) | slot_scnt_o[i][1]);
        end
    end

    // a type miss means the entry was new, restart its history
    always_comb begin
        if (corr_type_miss_i) begin
            hist_new = {{(HIST_W-1){1'b0}}, corr_taken_i};
        end else begin
            hist_new = {corr_history_i[HIST_W-2:0], corr_taken_i};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bht_q <= '0;
            pht_q <= '0;
        end else if (corr_update_i) begin
            bht_q[corr_pc_i[2]][wr_idx] <= hist_new;
            pht_q[pht_wr_idx]           <= next_scnt(corr_scnt_i, corr_taken_i);
        end
    end

endmodule

// ==== logic/bpu_ras.sv ====
/* return address stack, circular
   call corrections push pc+4, return corrections pop */
`timescale 1ns/1ps

module bpu_ras #(
    parameter int RAS_DEPTH = 8 // power of two, pointer wraps
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              corr_update_i,
    input  logic [31:0]       corr_pc_i,
    input  bpu_pkg::br_type_e corr_br_type_i,
    output logic [31:0]       ras_top_o
);
    import bpu_pkg::*;

    localparam int PTR_W = $clog2(RAS_DEPTH);

    logic [RAS_DEPTH-1:0][31:0] stack_q;
    logic [PTR_W-1:0]           top_q;    // slot holding the current top
    logic [PTR_W-1:0]           push_ptr;
    logic                       do_push;
    logic                       do_pop;

    assign push_ptr  = top_q + PTR_W'(1);
    assign do_push   = corr_update_i & (corr_br_type_i == BR_CALL);
    assign do_pop    = corr_update_i & (corr_br_type_i == BR_RET);
    assign ras_top_o = stack_q[top_q];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stack_q <= '0;  // empty stack reads 0
            top_q   <= '1;  // first push lands in slot 0
        end else if (do_push) begin
            stack_q[push_ptr] <= corr_pc_i + 32'd4; // overflow overwrites the oldest
            top_q             <= push_ptr;
        end else if (do_pop) begin
            top_q <= top_q - PTR_W'(1);
        end
    end

endmodule

// ==== logic/bpu_top.sv ====
/* next-fetch-address predictor top
   pc register, target buffer, direction predictor and return stack */
`timescale 1ns/1ps

module bpu_top #(
    parameter int          BTB_IDX_W = 9,
    parameter int          TAG_W     = 8,
    parameter int          HIST_W    = 5,
    parameter int          PHT_PC_W  = 8,
    parameter int          RAS_DEPTH = 8,
    parameter logic [31:0] INIT_PC   = 32'h1c00_0000
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush_i,
    input  logic [31:0]             redirect_pc_i,
    input  logic                    fetch_ready_i,
    input  logic                    corr_update_i,      // one record per cycle
    input  logic [31:0]             corr_pc_i,
    input  logic [31:0]             corr_target_i,
    input  bpu_pkg::br_type_e       corr_br_type_i,
    input  logic                    corr_is_branch_i,
    input  logic                    corr_taken_i,
    input  logic                    corr_type_miss_i,
    input  logic                    corr_target_miss_i,
    input  logic [HIST_W-1:0]       corr_history_i,
    input  bpu_pkg::scnt_t          corr_scnt_i,
    output logic [31:0]             pred_pc_o,
    output logic [1:0]              pred_mask_o,
    output logic [1:0]              pred_taken_o,
    output logic [1:0][31:0]        pred_target_o,
    output bpu_pkg::br_type_e [1:0] pred_br_type_o,
    output logic [1:0]              pred_hit_o,
    output bpu_pkg::scnt_t [1:0]    pred_scnt_o,
    output logic [1:0][HIST_W-1:0]  pred_history_o,
    output logic [31:0]             pred_next_pc_o
);
    import bpu_pkg::*;

    logic [31:0]           fetch_pc;
    logic [1:0]            slot_hit;
    br_type_e [1:0]        slot_type;
    logic [1:0][31:0]      slot_target;
    logic [1:0]            slot_taken;
    logic [1:0][HIST_W-1:0] slot_history;
    logic [31:0]           ras_top;

    bpu_pc_gen #(.INIT_PC(INIT_PC)) u_pc_gen (
        .clk(clk), .rst_n(rst_n), .flush_i(flush_i), .redirect_pc_i(redirect_pc_i),
        .fetch_ready_i(fetch_ready_i), .slot_taken_i(slot_taken), .slot_type_i(slot_type),
        .slot_target_i(slot_target), .ras_top_i(ras_top), .fetch_pc_o(fetch_pc),
        .target_o(pred_target_o), .mask_o(pred_mask_o), .next_pc_o(pred_next_pc_o)
    );

    bpu_btb #(.BTB_IDX_W(BTB_IDX_W), .TAG_W(TAG_W)) u_btb (
        .clk(clk), .rst_n(rst_n), .fetch_pc_i(fetch_pc), .corr_update_i(corr_update_i),
        .corr_pc_i(corr_pc_i), .corr_target_i(corr_target_i), .corr_br_type_i(corr_br_type_i),
        .corr_is_branch_i(corr_is_branch_i), .corr_type_miss_i(corr_type_miss_i),
        .corr_target_miss_i(corr_target_miss_i), .slot_hit_o(slot_hit),
        .slot_type_o(slot_type), .slot_target_o(slot_target), .tag_match_o(pred_hit_o)
    );

    bpu_dir_pred #(.BTB_IDX_W(BTB_IDX_W), .HIST_W(HIST_W), .PHT_PC_W(PHT_PC_W)) u_dir_pred (
        .clk(clk), .rst_n(rst_n), .fetch_pc_i(fetch_pc), .slot_hit_i(slot_hit),
        .slot_type_i(slot_type), .corr_update_i(corr_update_i), .corr_pc_i(corr_pc_i),
        .corr_taken_i(corr_taken_i), .corr_type_miss_i(corr_type_miss_i),
        .corr_history_i(corr_history_i), .corr_scnt_i(corr_scnt_i),
        .slot_taken_o(slot_taken), .slot_history_o(slot_history), .slot_scnt_o(pred_scnt_o)
    );

    bpu_ras #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
        .clk(clk), .rst_n(rst_n), .corr_update_i(corr_update_i), .corr_pc_i(corr_pc_i),
        .corr_br_type_i(corr_br_type_i), .ras_top_o(ras_top)
    );

    assign pred_pc_o      = fetch_pc;
    assign pred_taken_o   = slot_taken;
    assign pred_br_type_o = slot_type;
    assign pred_history_o = slot_history;

endmodule

// ==== tests/bpu_chk.sv ====
/* assertions bound into the predictor top
   reset state, slot mask legality and flush redirect */
`timescale 1ns/1ps

module bpu_chk (
    input logic        clk,
    input logic        rst_n,
    input logic        flush_i,
    input logic [31:0] redirect_pc_i,
    input logic [31:0] pc_i,
    input logic [1:0]  mask_i,
    input logic [1:0]  taken_i
);

    // entering at an odd slot leaves slot 0 off
    mask_entry: assert property (@(posedge clk) disable iff (!rst_n)
        flush_i |=> mask_i[0] == !$past(redirect_pc_i[2]))
        else $error("slot mask %b wrong for redirected pc %h", mask_i, pc_i);

    // redirect lands on the next edge even when stalled
    flush_load: assert property (@(posedge clk) disable iff (!rst_n)
        flush_i |=> pc_i == $past(redirect_pc_i))
        else $error("fetch pc %h did not take the redirect", pc_i);

    // tables are empty right after a reset edge
    reset_quiet: assert property (@(posedge clk) !rst_n |=> taken_i == 2'b00)
        else $error("taken set in the first cycle after reset");

endmodule

bind bpu_top bpu_chk u_chk (
    .clk(clk), .rst_n(rst_n), .flush_i(flush_i), .redirect_pc_i(redirect_pc_i),
    .pc_i(pred_pc_o), .mask_i(pred_mask_o), .taken_i(pred_taken_o)
);

// ==== tests/bpu_tb.sv ====
/* predictor testbench, lfsr stimulus checked against a behavioural model
   fetch, flush, jumps and calls, conditionals, returns, random mix */
`timescale 1ns/1ps

module bpu_tb;
    import bpu_pkg::*;

    localparam logic [31:0] INIT_PC = 32'h1c00_0000;
    localparam int MIX_CYC  = 2000;
    // reset, then tests 1 to 6 as upper bounds
    localparam int STIM_CYC = 10 + 18 + 120 + 30 + 200 + 310 + MIX_CYC;
    localparam int LIMIT    = STIM_CYC + 200;

    logic        clk, rst_n, flush_i, fetch_ready_i;
    logic        corr_update_i, corr_is_branch_i, corr_taken_i;
    logic        corr_type_miss_i, corr_target_miss_i;
    logic [31:0] redirect_pc_i, corr_pc_i, corr_target_i;
    br_type_e    corr_br_type_i;
    logic [4:0]  corr_history_i;
    scnt_t       corr_scnt_i;
    logic [31:0] pred_pc_o, pred_next_pc_o;
    logic [1:0]  pred_mask_o, pred_taken_o, pred_hit_o;
    logic [1:0][31:0] pred_target_o;
    br_type_e [1:0]   pred_br_type_o;
    scnt_t [1:0]      pred_scnt_o;
    logic [1:0][4:0]  pred_history_o;

    // model state, same shape as the dut tables
    logic        m_valid [2][512];
    logic        m_br    [2][512];
    logic [7:0]  m_tag   [2][512];
    br_type_e    m_type  [2][512];
    logic [31:0] m_tgt   [2][512];
    logic [4:0]  m_bht   [2][512];
    scnt_t       m_pht   [8192];
    logic [31:0] m_ras   [8];
    logic [2:0]  m_top;
    logic [31:0] m_pc, exp_next;

    logic [31:0] site_pc [16];
    logic [31:0] site_tgt [16];
    br_type_e    site_type [16];
    logic [31:0] lfsr = 32'h8b52_6365;
    int          cyc = 0;
    int          test_err = 0;
    int          total_err = 0;
    int          fails = 0;

    bpu_top #(.INIT_PC(INIT_PC)) bpu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // hard stop if a wait never returns
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > LIMIT) begin
            $display("timeout: no end of test after %0d cycles", LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [8:0] idx_of(input logic [31:0] pc);
        return pc[11:3] ^ pc[17:9]; // two pc fields folded
    endfunction

    function automatic scnt_t sat_step(input scnt_t c, input logic t);
        return t ? ((c == 2'd3) ? c : c + 2'd1) : ((c == 2'd0) ? c : c - 2'd1);
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            test_err++;
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < 512; j++) begin
                m_valid[i][j] = 1'b0;
                m_br[i][j]    = 1'b0;
                m_tag[i][j]   = '0;
                m_type[i][j]  = BR_NORMAL;
                m_tgt[i][j]   = '0;
                m_bht[i][j]   = '0;
            end
        end
        for (int p = 0; p < 8192; p++) begin
            m_pht[p] = '0;
        end
        for (int s = 0; s < 8; s++) begin
            m_ras[s] = '0;
        end
        m_top    = 3'd7; // empty, first push goes to slot 0
        m_pc     = INIT_PC;
        exp_next = '0;
    endtask

    // expected outputs for the current model pc
    task automatic check_outputs();
        logic [8:0]       ix;
        logic [1:0]       tm, hit, tk, mask;
        logic [1:0][31:0] tgt;
        logic [1:0][4:0]  hist;
        scnt_t [1:0]      sc;
        br_type_e [1:0]   ty;
        ix = idx_of(m_pc);
        for (int i = 0; i < 2; i++) begin
            tm[i]   = m_valid[i][ix] && m_tag[i][ix] == m_pc[19:12];
            hit[i]  = tm[i] && m_br[i][ix];
            ty[i]   = m_type[i][ix];
            hist[i] = m_bht[i][ix];
            sc[i]   = m_pht[{hist[i], m_pc[10:3]}];
            tk[i]   = hit[i] && (ty[i] != BR_NORMAL || sc[i] >= 2'd2);
            tgt[i]  = (ty[i] == BR_RET) ? m_ras[m_top] : m_tgt[i][ix];
        end
        mask = {~(tk[0] & ~m_pc[2]), ~m_pc[2]};
        if (tk[0] && !m_pc[2]) begin
            exp_next = tgt[0];
        end else if (tk[1]) begin
            exp_next = tgt[1];
        end else begin
            exp_next = {m_pc[31:3] + 29'd1, 3'b000};
        end
        check_val("pred_pc_o", 64'(pred_pc_o), 64'(m_pc));
        check_val("pred_mask_o", 64'(pred_mask_o), 64'(mask));
        check_val("pred_taken_o", 64'(pred_taken_o), 64'(tk));
        check_val("pred_target_o", 64'(pred_target_o), 64'(tgt));
        check_val("pred_br_type_o", 64'(pred_br_type_o), 64'(ty));
        check_val("pred_hit_o", 64'(pred_hit_o), 64'(tm));
        check_val("pred_scnt_o", 64'(pred_scnt_o), 64'(sc));
        check_val("pred_history_o", 64'(pred_history_o), 64'(hist));
        check_val("pred_next_pc_o", 64'(pred_next_pc_o), 64'(exp_next));
    endtask

    // apply the inputs seen at this edge
    task automatic update_model();
        logic [8:0] wi;
        logic       b;
        wi = idx_of(corr_pc_i);
        b  = corr_pc_i[2]; // bank follows the slot
        if (corr_update_i) begin
            if (corr_type_miss_i || corr_target_miss_i) begin
                m_valid[b][wi] = 1'b1;
                m_tag[b][wi]   = corr_pc_i[19:12];
                m_type[b][wi]  = corr_br_type_i;
                m_tgt[b][wi]   = corr_target_i;
                m_br[b][wi]    = corr_is_branch_i;
            end
            m_bht[b][wi] = corr_type_miss_i ? {4'd0, corr_taken_i}
                                            : {corr_history_i[3:0], corr_taken_i};
            m_pht[{corr_history_i, corr_pc_i[10:3]}] = sat_step(corr_scnt_i, corr_taken_i);
            if (corr_br_type_i == BR_CALL) begin
                m_top        = m_top + 3'd1; // wraps over the oldest
                m_ras[m_top] = corr_pc_i + 32'd4;
            end else if (corr_br_type_i == BR_RET) begin
                m_top = m_top - 3'd1;
            end
        end
        if (flush_i) begin
            m_pc = redirect_pc_i;
        end else if (fetch_ready_i) begin
            m_pc = exp_next;
        end
    endtask

    // one cycle, check mid-cycle, strobes drop after the edge
    task automatic tick();
        @(negedge clk);
        check_outputs();
        @(posedge clk);
        update_model();
        #1;
        corr_update_i = 1'b0;
        flush_i       = 1'b0;
    endtask

    // correction record as execute would send it
    task automatic drive_rec(input logic [31:0] pc, input logic [31:0] tgt,
                             input br_type_e ty, input logic taken);
        logic [8:0] wi;
        logic       b;
        logic       known;
        wi    = idx_of(pc);
        b     = pc[2];
        known = m_valid[b][wi] && m_br[b][wi] && m_tag[b][wi] == pc[19:12]
                && m_type[b][wi] == ty;
        corr_update_i      = 1'b1;
        corr_pc_i          = pc;
        corr_target_i      = tgt;
        corr_br_type_i     = ty;
        corr_is_branch_i   = 1'b1;
        corr_taken_i       = (ty == BR_NORMAL) ? taken : 1'b1;
        corr_type_miss_i   = !known;
        corr_target_miss_i = known && ty != BR_RET && m_tgt[b][wi] != tgt;
        corr_history_i     = m_bht[b][wi];
        corr_scnt_i        = m_pht[{m_bht[b][wi], pc[10:3]}];
    endtask

    task automatic drive_site(input int k, input logic taken);
        drive_rec(site_pc[k], site_tgt[k], site_type[k], taken);
    endtask

    task automatic end_test(input string name);
        $display("test %-12s %s, %0d errors", name, (test_err == 0) ? "ok" : "FAILED", test_err);
        total_err += test_err;
        if (test_err != 0) begin
            fails++;
        end
        test_err = 0;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] pair_pc;
        logic        is_call;
        int          k;
        rst_n              = 1'b0;
        flush_i            = 1'b0;
        redirect_pc_i      = '0;
        fetch_ready_i      = 1'b0;
        corr_update_i      = 1'b0;
        corr_pc_i          = '0;
        corr_target_i      = '0;
        corr_br_type_i     = BR_NORMAL;
        corr_is_branch_i   = 1'b0;
        corr_taken_i       = 1'b0;
        corr_type_miss_i   = 1'b0;
        corr_target_miss_i = 1'b0;
        corr_history_i     = '0;
        corr_scnt_i        = '0;
        reset_model();
        // 16 sites, low index bits = site number, type = number mod 4
        for (int s = 0; s < 16; s++) begin
            r            = rand_bits(32);
            site_pc[s]   = {r[31:9], {r[8:7], 4'(s)} ^ r[14:9], r[2], 2'b00};
            site_tgt[s]  = rand_bits(30) << 2;
            site_type[s] = br_type_e'(2'(s));
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // 1: sequential fetch, odd-slot entry, hold under back-pressure
        fetch_ready_i = 1'b1;
        repeat (8) tick();
        flush_i       = 1'b1;
        redirect_pc_i = INIT_PC + 32'h104;
        tick();
        fetch_ready_i = 1'b0;
        repeat (4) tick();
        fetch_ready_i = 1'b1;
        repeat (4) tick();
        end_test("sequential");

        // 2: random redirects against random ready
        repeat (120) begin
            fetch_ready_i = (rand_bits(1) != 32'd0);
            flush_i       = (rand_bits(3) == 32'd0);
            redirect_pc_i = rand_bits(30) << 2;
            tick();
        end
        end_test("flush");

        // 3: jumps and calls learned in one record, pc parked on the site
        fetch_ready_i = 1'b0;
        for (int s = 0; s < 16; s++) begin
            if (site_type[s] == BR_JUMP || site_type[s] == BR_CALL) begin
                drive_site(s, 1'b1);
                flush_i       = 1'b1;
                redirect_pc_i = site_pc[s];
                tick();
                tick();
                check_val("pred_next_pc_o", 64'(pred_next_pc_o), 64'(site_tgt[s]));
                check_val("pred_taken_o", 64'(pred_taken_o[site_pc[s][2]]), 64'd1);
            end
        end
        pair_pc = {site_pc[1][31:3], 3'b000}; // both slots taken, slot 0 wins
        drive_rec(pair_pc | 32'd4, 32'h0000_4000, BR_JUMP, 1'b1);
        tick();
        drive_rec(pair_pc, 32'h0000_8000, BR_JUMP, 1'b1);
        flush_i       = 1'b1;
        redirect_pc_i = pair_pc;
        tick();
        tick();
        check_val("pred_next_pc_o", 64'(pred_next_pc_o), 64'h8000);
        flush_i       = 1'b1;
        redirect_pc_i = pair_pc | 32'd4;
        tick();
        tick();
        check_val("pred_next_pc_o", 64'(pred_next_pc_o), 64'h4000);
        end_test("jump_call");

        // 4: conditionals, each record also parks the pc on its site
        repeat (200) begin
            k = 4 * int'(rand_bits(2));
            drive_site(k, rand_bits(1) != 32'd0);
            if (rand_bits(3) == 32'd0) begin
                corr_type_miss_i = 1'b1; // history restarts
            end
            flush_i       = 1'b1;
            redirect_pc_i = site_pc[k];
            tick();
        end
        end_test("conditional");

        // 5: call/return traffic, deep enough to wrap the stack
        for (int s = 3; s < 16; s += 4) begin
            drive_site(s, 1'b1);
            tick();
        end
        for (int i = 0; i < 300; i++) begin
            is_call = (i < 100) ? (rand_bits(2) != 32'd0) : (rand_bits(1) != 32'd0);
            k       = (is_call ? 2 : 3) + 4 * int'(rand_bits(2));
            drive_site(k, 1'b1);
            flush_i       = 1'b1;
            redirect_pc_i = site_pc[3 + 4 * int'(rand_bits(2))];
            tick();
        end
        end_test("return");

        // 6: everything mixed, corrections also land while stalled
        repeat (MIX_CYC) begin
            fetch_ready_i = (rand_bits(2) != 32'd0);
            if (rand_bits(1) != 32'd0) begin
                drive_site(int'(rand_bits(4)), rand_bits(1) != 32'd0);
                if (rand_bits(4) == 32'd0) begin
                    corr_is_branch_i   = 1'b0; // tag match without a hit
                    corr_target_miss_i = 1'b1;
                end
                if (rand_bits(3) == 32'd0) begin
                    corr_type_miss_i = 1'b1;
                end
            end
            if (rand_bits(3) == 32'd0) begin
                flush_i = 1'b1;
                if (rand_bits(1) != 32'd0) begin
                    redirect_pc_i = site_pc[int'(rand_bits(4))];
                end else begin
                    redirect_pc_i = rand_bits(30) << 2;
                end
            end
            tick();
        end
        end_test("random_mix");

        $display("tests 6, failed %0d, errors %0d, cycles %0d", fails, total_err, cyc);
        if (fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
logic/bpu_pkg.sv
logic/bpu_pc_gen.sv
logic/bpu_btb.sv
logic/bpu_dir_pred.sv
logic/bpu_ras.sv
logic/bpu_top.sv
tests/bpu_chk.sv
tests/bpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the predictor regression with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module bpu_tb -Mdir obj_dir -o bpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/bpu_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
